//--- flist.f
common/board_pkg.sv
design/spi_byte_rx.sv
mist_io/user_io_cfg.sv
mist_io/rom_download.sv
audio/sigma_delta_dac.sv
video/video_out.sv
design/jtgng_board.sv
verif/tb_jtgng_board.sv

//--- verif/tb_jtgng_board.sv
`timescale 1ns/1ps

module tb_jtgng_board;
	import board_pkg::*;

	localparam int clk_period   = 20;
	localparam int hs_len       = 16;
	localparam int half_bit     = 4;   // Clock cycles per SCK phase
	localparam int cfg_frames   = 24;
	localparam int dl_frames    = 2;
	localparam int max_words    = 40;
	localparam int audio_rounds = 4;
	localparam int video_len    = 600;
	localparam int spi_bytes    = (cfg_frames + 2) * 6 + dl_frames * (2 * max_words + 1);
	localparam int run_cycles   = spi_bytes * 8 * 2 * half_bit
		+ (cfg_frames + dl_frames + 2) * 32 + audio_rounds * 560 + 2 * (video_len + 24) + 2000;

	logic                    clk_gng;
	logic                    rst_n;
	logic                    SPI_SCK;
	logic                    SPI_DI;
	logic                    SPI_SS2;
	logic                    CONF_DATA0;
	logic [col_w-1:0]        red;
	logic [col_w-1:0]        green;
	logic [col_w-1:0]        blue;
	logic                    LHBL;
	logic                    LVBL;
	logic signed [snd_w-1:0] snd_left;
	logic signed [snd_w-1:0] snd_right;
	logic [vga_w-1:0]        VGA_R;
	logic [vga_w-1:0]        VGA_G;
	logic [vga_w-1:0]        VGA_B;
	logic                    VGA_HS;
	logic                    VGA_VS;
	logic                    AUDIO_L;
	logic                    AUDIO_R;
	logic                    downloading;
	logic                    romload_wr;
	logic [rom_aw-1:0]       romload_addr;
	logic [rom_dw-1:0]       romload_data;
	logic [7:0]              game_joy1;
	logic [7:0]              game_joy2;
	logic                    soft_rst;
	logic                    dip_test;
	logic                    dip_upright;
	logic                    enable_scr;
	logic                    enable_obj;

	// Reference registers of the configuration channel
	logic [status_w-1:0] st_m;
	logic [7:0]          joy1_m;
	logic [7:0]          joy2_m;

	logic [7:0]        frame_buf [0:127];
	logic [rom_aw-1:0] wr_addr [0:127];   // Captured ROM writes
	logic [rom_dw-1:0] wr_data [0:127];
	int                wr_cnt;

	jtgng_board #(.hs_len(hs_len)) UUT (.*);

	initial begin
		clk_gng = 1'b0;
		forever #(clk_period / 2) clk_gng = ~clk_gng;
	end

	initial begin
		#(run_cycles * clk_period);
		abort_run("Simulation timed out before all tests completed");
	end

	always @(posedge clk_gng) begin
		if (rst_n && romload_wr && wr_cnt < 128) begin
			wr_addr[wr_cnt] = romload_addr;
			wr_data[wr_cnt] = romload_data;
			wr_cnt          = wr_cnt + 1;
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_status(input logic [status_w-1:0] got, input logic [status_w-1:0] exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_word(input logic [rom_aw-1:0] addr, input logic [rom_aw-1:0] exp_addr,
		input logic [rom_dw-1:0] data, input logic [rom_dw-1:0] exp_data);
		if (addr !== exp_addr || data !== exp_data)
			abort_run($sformatf("Fail at %0t: ROM write %h:%h, expected %h:%h", $time,
				addr, data, exp_addr, exp_data));
	endtask

	task automatic check_count(input int got, input int exp, input int tol, input string what);
		if (got > exp + tol || got < exp - tol)
			abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_colour(input logic [vga_w-1:0] got, input logic [vga_w-1:0] exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// 4-bit colour followed by its top bits
	function automatic logic [vga_w-1:0] expand(input logic [col_w-1:0] c);
		return {c, c[col_w-1 -: vga_w-col_w]};
	endfunction

	function automatic void update_model(input logic [7:0] op, input logic [7:0] data);
		case (op)
			cmd_status: st_m   = data;
			cmd_joy0:   joy2_m = data;
			cmd_joy1:   joy1_m = data;
			default: ;
		endcase
	endfunction

	task automatic check_controls();
		logic [status_w-1:0] exp_ctl;
		logic [status_w-1:0] obs_ctl;
		exp_ctl = {1'b0, st_m[6], 1'b0, ~st_m[4], ~st_m[3], st_m[2], ~st_m[1], 1'b0};
		obs_ctl = {1'b0, soft_rst, 1'b0, enable_obj, enable_scr, dip_upright, dip_test, 1'b0};
		check_status(obs_ctl, exp_ctl, "control levels");
		check_byte(game_joy1, ~joy1_m, "game_joy1");
		check_byte(game_joy2, ~joy2_m, "game_joy2");
	endtask

	task automatic send_spi_bit(input logic b);
		SPI_SCK <= 1'b0;
		SPI_DI  <= b;
		repeat (half_bit) @(posedge clk_gng);
		SPI_SCK <= 1'b1;   // Sampled on this edge
		repeat (half_bit) @(posedge clk_gng);
	endtask

	task automatic send_frame(input logic to_rom, input int nbytes, input int partial);
		int i;
		int k;
		if (to_rom)
			SPI_SS2 <= 1'b0;
		else
			CONF_DATA0 <= 1'b0;
		repeat (half_bit) @(posedge clk_gng);
		for (i = 0; i < nbytes; i++) begin
			for (k = 7; k >= 0; k--)
				send_spi_bit(frame_buf[i][k]);
			if (to_rom)
				check_level(downloading, 1'b1, "downloading");
		end
		for (k = 0; k < partial; k++)
			send_spi_bit($urandom % 2);   // Cut off before the byte ends
		SPI_SCK <= 1'b0;
		repeat (half_bit) @(posedge clk_gng);
		SPI_SS2    <= 1'b1;
		CONF_DATA0 <= 1'b1;
		repeat (4 * half_bit) @(posedge clk_gng);
	endtask

	task automatic run_cfg_frame();
		logic [7:0] op;
		int         kind;
		int         nbytes;
		int         partial;
		int         i;
		kind = $urandom % 4;
		case (kind)
			0: op = cmd_status;
			1: op = cmd_joy0;
			2: op = cmd_joy1;
			default: begin
				do op = $urandom;
				while (op == cmd_status || op == cmd_joy0 || op == cmd_joy1);
			end
		endcase
		frame_buf[0] = op;
		for (i = 1; i < 8; i++)
			frame_buf[i] = $urandom;
		if ($urandom % 5 == 0) begin
			nbytes  = 1;   // Data byte never completes
			partial = 1 + $urandom % 7;
		end else begin
			nbytes  = 2 + $urandom % 3;
			partial = ($urandom % 4 == 0) ? 1 + $urandom % 7 : 0;
		end
		if (nbytes >= 2)
			update_model(op, frame_buf[1]);
		send_frame(1'b0, nbytes, partial);
		check_controls();
	endtask

	task automatic send_status(input logic [7:0] value);
		frame_buf[0] = cmd_status;
		frame_buf[1] = value;
		update_model(cmd_status, value);
		send_frame(1'b0, 2, 0);
		check_controls();
	endtask

	task automatic run_download();
		int nwords;
		int nbytes;
		int i;
		nwords = 1 + $urandom % max_words;
		nbytes = 2 * nwords + $urandom % 2;   // Odd tail byte gives no write
		for (i = 0; i < nbytes; i++)
			frame_buf[i] = $urandom;
		wr_cnt = 0;
		send_frame(1'b1, nbytes, 0);
		check_count(wr_cnt, nwords, 0, "ROM write count");
		for (i = 0; i < nwords; i++)
			check_word(wr_addr[i], rom_aw'(i), wr_data[i], {frame_buf[2*i+1], frame_buf[2*i]});
		check_level(downloading, 1'b0, "downloading after release");
	endtask

	task automatic run_audio();
		logic signed [snd_w-1:0] sl;
		logic signed [snd_w-1:0] sr;
		int                      ones_l;
		int                      ones_r;
		int                      i;
		sl = $urandom;
		sr = $urandom;
		snd_left  <= sl;
		snd_right <= sr;
		repeat (16) @(posedge clk_gng);
		ones_l = 0;
		ones_r = 0;
		for (i = 0; i < 512; i++) begin
			@(posedge clk_gng);
			ones_l = ones_l + AUDIO_L;
			ones_r = ones_r + AUDIO_R;
		end
		check_count(ones_l, sl + 256, 1, "AUDIO_L ones");
		check_count(ones_r, sr + 256, 1, "AUDIO_R ones");
	endtask

	task automatic run_video(input int n);
		logic [3*vga_w+1:0] exp_q1;   // {r, g, b, hs, vs}
		logic [3*vga_w+1:0] exp_q2;
		logic [col_w-1:0]   r;
		logic [col_w-1:0]   g;
		logic [col_w-1:0]   b;
		logic               hb;
		logic               vb;
		logic               prev_hb;
		logic               show;
		logic               hs_exp;
		int                 hs_left;
		int                 i;
		prev_hb = LHBL;
		hs_left = 0;
		exp_q1  = '0;
		exp_q2  = '0;
		for (i = 0; i < n + 2; i++) begin
			@(posedge clk_gng);
			if (i >= 2) begin
				check_colour(VGA_R, exp_q2[3*vga_w+1 -: vga_w], "VGA_R");
				check_colour(VGA_G, exp_q2[2*vga_w+1 -: vga_w], "VGA_G");
				check_colour(VGA_B, exp_q2[vga_w+1 -: vga_w], "VGA_B");
				check_level(VGA_HS, exp_q2[1], "VGA_HS");
				check_level(VGA_VS, exp_q2[0], "VGA_VS");
			end
			exp_q2 = exp_q1;
			if (i < n) begin
				r  = $urandom;
				g  = $urandom;
				b  = $urandom;
				hb = ($urandom % 48) != 0;
				vb = ($urandom % 16) != 0;
				red   <= r;
				green <= g;
				blue  <= b;
				LHBL  <= hb;
				LVBL  <= vb;
				show = (hb && vb) || st_m[5];   // Mixing off keeps colour in blanking
				if (prev_hb && !hb) begin
					hs_exp  = 1'b0;
					hs_left = hs_len - 1;
				end else if (hs_left > 0) begin
					hs_exp  = 1'b0;
					hs_left = hs_left - 1;
				end else begin
					hs_exp = 1'b1;
				end
				prev_hb = hb;
				exp_q1 = show ? {expand(r), expand(g), expand(b), hs_exp, vb}
					: {{(3*vga_w){1'b0}}, hs_exp, vb};
			end
		end
		LHBL <= 1'b1;
		LVBL <= 1'b1;
		repeat (hs_len + 4) @(posedge clk_gng);
	endtask

	initial begin
		void'($urandom(32'haac2));
		rst_n      = 1'b0;
		SPI_SCK    = 1'b0;
		SPI_DI     = 1'b0;
		SPI_SS2    = 1'b1;
		CONF_DATA0 = 1'b1;
		red        = '0;
		green      = '0;
		blue       = '0;
		LHBL       = 1'b1;
		LVBL       = 1'b1;
		snd_left   = '0;
		snd_right  = '0;
		st_m       = '0;
		joy1_m     = 8'd0;
		joy2_m     = 8'd0;
		wr_cnt     = 0;
		repeat (4) @(posedge clk_gng);

		// Reset values
		check_level(romload_wr, 1'b0, "romload_wr in reset");
		check_level(downloading, 1'b0, "downloading in reset");
		check_level(AUDIO_L, 1'b0, "AUDIO_L in reset");
		check_level(AUDIO_R, 1'b0, "AUDIO_R in reset");
		check_level(VGA_HS, 1'b1, "VGA_HS in reset");
		check_level(VGA_VS, 1'b1, "VGA_VS in reset");
		check_colour(VGA_R, '0, "VGA_R in reset");
		check_colour(VGA_G, '0, "VGA_G in reset");
		check_colour(VGA_B, '0, "VGA_B in reset");
		check_controls();
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_gng);

		repeat (cfg_frames) run_cfg_frame();
		repeat (dl_frames) run_download();
		repeat (audio_rounds) run_audio();
		send_status(8'($urandom) & 8'hdf);   // Mixing on
		run_video(video_len);
		send_status(8'($urandom) | 8'h20);
		run_video(video_len);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- design/jtgng_board.sv
`timescale 1ns/1ps

module jtgng_board
	import board_pkg::*;
#(
	parameter int hs_len = 32
) (
	input  logic                    clk_gng,
	input  logic                    rst_n,
	input  logic                    SPI_SCK,
	input  logic                    SPI_DI,
	input  logic                    SPI_SS2,
	input  logic                    CONF_DATA0,
	input  logic [col_w-1:0]        red,
	input  logic [col_w-1:0]        green,
	input  logic [col_w-1:0]        blue,
	input  logic                    LHBL,
	input  logic                    LVBL,
	input  logic signed [snd_w-1:0] snd_left,
	input  logic signed [snd_w-1:0] snd_right,
	output logic [vga_w-1:0]        VGA_R,
	output logic [vga_w-1:0]        VGA_G,
	output logic [vga_w-1:0]        VGA_B,
	output logic                    VGA_HS,
	output logic                    VGA_VS,
	output logic                    AUDIO_L,
	output logic                    AUDIO_R,
	output logic                    downloading,
	output logic                    romload_wr,
	output logic [rom_aw-1:0]       romload_addr,
	output logic [rom_dw-1:0]       romload_data,
	output logic [7:0]              game_joy1,
	output logic [7:0]              game_joy2,
	output logic                    soft_rst,
	output logic                    dip_test,
	output logic                    dip_upright,
	output logic                    enable_scr,
	output logic                    enable_obj
);

	logic                cfg_valid;
	logic                cfg_start;
	logic [7:0]          cfg_data;
	logic                dl_valid;
	logic                dl_start;
	logic                dl_sel;
	logic [7:0]          dl_data;
	logic [status_w-1:0] status;
	logic [7:0]          joystick1;
	logic [7:0]          joystick2;
	logic                en_mixing;

	// Configuration channel
	spi_byte_rx u_cfg_rx (
		.clk_gng     (clk_gng),
		.rst_n       (rst_n),
		.sck         (SPI_SCK),
		.sdi         (SPI_DI),
		.ss          (CONF_DATA0),
		.byte_valid  (cfg_valid),
		.frame_start (cfg_start),
		.selected    (),
		.byte_data   (cfg_data)
	);

	// ROM image channel
	spi_byte_rx u_dl_rx (
		.clk_gng     (clk_gng),
		.rst_n       (rst_n),
		.sck         (SPI_SCK),
		.sdi         (SPI_DI),
		.ss          (SPI_SS2),
		.byte_valid  (dl_valid),
		.frame_start (dl_start),
		.selected    (dl_sel),
		.byte_data   (dl_data)
	);

	user_io_cfg u_cfg (
		.clk_gng     (clk_gng),
		.rst_n       (rst_n),
		.frame_start (cfg_start),
		.byte_valid  (cfg_valid),
		.byte_data   (cfg_data),
		.status      (status),
		.joystick1   (joystick1),
		.joystick2   (joystick2)
	);

	rom_download u_dl (
		.clk_gng      (clk_gng),
		.rst_n        (rst_n),
		.frame_start  (dl_start),
		.byte_valid   (dl_valid),
		.selected     (dl_sel),
		.byte_data    (dl_data),
		.downloading  (downloading),
		.romload_wr   (romload_wr),
		.romload_addr (romload_addr),
		.romload_data (romload_data)
	);

	// Joystick bits and most menu options are active low at the game
	assign game_joy1   = ~joystick1;
	assign game_joy2   = ~joystick2;
	assign dip_test    = ~status[1];
	assign dip_upright = status[2];
	assign enable_scr  = ~status[3];
	assign enable_obj  = ~status[4];
	assign en_mixing   = ~status[5];   // Screen filter option
	assign soft_rst    = status[6];

	sigma_delta_dac #(.width(snd_w)) u_dac_left (
		.clk_gng (clk_gng),
		.rst_n   (rst_n),
		.din     (snd_left),
		.dout    (AUDIO_L)
	);

	sigma_delta_dac #(.width(snd_w)) u_dac_right (
		.clk_gng (clk_gng),
		.rst_n   (rst_n),
		.din     (snd_right),
		.dout    (AUDIO_R)
	);

	video_out #(.hs_len(hs_len)) u_video (
		.clk_gng   (clk_gng),
		.rst_n     (rst_n),
		.lhbl      (LHBL),
		.lvbl      (LVBL),
		.en_mixing (en_mixing),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.vga_r     (VGA_R),
		.vga_g     (VGA_G),
		.vga_b     (VGA_B),
		.vga_hs    (VGA_HS),
		.vga_vs    (VGA_VS)
	);

endmodule

//--- video/video_out.sv
`timescale 1ns/1ps

module video_out
	import board_pkg::*;
#(
	parameter int hs_len = 32
) (
	input  logic             clk_gng,
	input  logic             rst_n,
	input  logic             lhbl,
	input  logic             lvbl,
	input  logic             en_mixing,
	input  logic [col_w-1:0] red,
	input  logic [col_w-1:0] green,
	input  logic [col_w-1:0] blue,
	output logic [vga_w-1:0] vga_r,
	output logic [vga_w-1:0] vga_g,
	output logic [vga_w-1:0] vga_b,
	output logic             vga_hs,
	output logic             vga_vs
);

	localparam int cnt_w = $clog2(hs_len + 1);
	localparam int ext_w = vga_w - col_w;

	logic             show;
	logic             lhbl_d;
	logic             hb_fall;
	logic [cnt_w-1:0] hs_cnt;

	// Without mixing the blanked area keeps its colour
	assign show    = (lhbl & lvbl) | ~en_mixing;
	assign hb_fall = lhbl_d & ~lhbl;

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (show) begin
			vga_r <= {red, red[col_w-1 -: ext_w]};   // Top bits repeat at the bottom
			vga_g <= {green, green[col_w-1 -: ext_w]};
			vga_b <= {blue, blue[col_w-1 -: ext_w]};
		end else begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end
	end

	// Sync pulse starts on the falling edge of horizontal blanking
	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			lhbl_d <= 1'b0;
			hs_cnt <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			lhbl_d <= lhbl;
			vga_vs <= lvbl;
			if (hb_fall) begin
				hs_cnt <= cnt_w'(hs_len - 1);
				vga_hs <= 1'b0;
			end else if (hs_cnt != '0) begin
				hs_cnt <= hs_cnt - 1'b1;
			end else begin
				vga_hs <= 1'b1;
			end
		end
	end

endmodule

//--- audio/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int width = 9
) (
	input  logic                    clk_gng,
	input  logic                    rst_n,
	input  logic signed [width-1:0] din,
	output logic                    dout
);

	logic signed [width-1:0] din_r;
	logic [width-1:0]        offset;
	logic [width-1:0]        acc;
	logic [width:0]          sum;

	// Adding half scale only flips the sign bit
	assign offset = {~din_r[width-1], din_r[width-2:0]};
	assign sum    = {1'b0, acc} + {1'b0, offset};

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			din_r <= '0;
			acc   <= '0;
			dout  <= 1'b0;
		end else begin
			din_r <= din;
			acc   <= sum[width-1:0];
			dout  <= sum[width];   // Carry out is the bit stream
		end
	end

endmodule

//--- mist_io/rom_download.sv
`timescale 1ns/1ps

module rom_download
	import board_pkg::*;
(
	input  logic              clk_gng,
	input  logic              rst_n,
	input  logic              frame_start,
	input  logic              byte_valid,
	input  logic              selected,
	input  logic [7:0]        byte_data,
	output logic              downloading,
	output logic              romload_wr,
	output logic [rom_aw-1:0] romload_addr,
	output logic [rom_dw-1:0] romload_data
);

	dl_state_e  phase;
	logic [7:0] low_byte;

	assign downloading = selected;

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			phase        <= dl_low;
			romload_wr   <= 1'b0;
			romload_addr <= '0;
		end else begin
			romload_wr <= 1'b0;
			if (frame_start) begin
				phase        <= dl_low;
				romload_addr <= '0;   // Each download starts over
			end else begin
				if (romload_wr) begin
					romload_addr <= romload_addr + 1'b1;
				end
				if (byte_valid) begin
					case (phase)
						dl_low:  phase <= dl_high;
						dl_high: begin
							phase      <= dl_low;
							romload_wr <= 1'b1;
						end
						default: phase <= dl_low;
					endcase
				end
			end
		end
	end

	// First byte is the low half of the word
	always_ff @(posedge clk_gng) begin
		if (byte_valid && phase == dl_low) begin
			low_byte <= byte_data;
		end
		if (byte_valid && phase == dl_high) begin
			romload_data <= {byte_data, low_byte};
		end
	end

endmodule

//--- mist_io/user_io_cfg.sv
`timescale 1ns/1ps

module user_io_cfg
	import board_pkg::*;
(
	input  logic                clk_gng,
	input  logic                rst_n,
	input  logic                frame_start,
	input  logic                byte_valid,
	input  logic [7:0]          byte_data,
	output logic [status_w-1:0] status,
	output logic [7:0]          joystick1,
	output logic [7:0]          joystick2
);

	// 0 waits for the opcode, 1 for its data, 2 ignores the rest
	logic [1:0] byte_idx;
	user_cmd_e  opcode;

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			byte_idx <= 2'd0;
		end else if (frame_start) begin
			byte_idx <= 2'd0;
		end else if (byte_valid && byte_idx != 2'd2) begin
			byte_idx <= byte_idx + 2'd1;
		end
	end

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			opcode <= cmd_status;
		end else if (byte_valid && byte_idx == 2'd0) begin
			opcode <= user_cmd_e'(byte_data);
		end
	end

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			status    <= '0;
			joystick1 <= 8'd0;
			joystick2 <= 8'd0;
		end else if (byte_valid && byte_idx == 2'd1 && !frame_start) begin
			case (opcode)
				cmd_status: status    <= byte_data[status_w-1:0];
				cmd_joy0:   joystick2 <= byte_data;   // Crossed on purpose
				cmd_joy1:   joystick1 <= byte_data;
				default: ;  // Unknown command
			endcase
		end
	end

endmodule

//--- design/spi_byte_rx.sv
`timescale 1ns/1ps

module spi_byte_rx (
	input  logic       clk_gng,
	input  logic       rst_n,
	input  logic       sck,
	input  logic       sdi,
	input  logic       ss,
	output logic       byte_valid,
	output logic       frame_start,
	output logic       selected,
	output logic [7:0] byte_data
);

	logic [1:0] sck_ff;
	logic [1:0] sdi_ff;
	logic [1:0] ss_ff;
	logic       sck_prev;
	logic       ss_prev;
	logic       sck_rise;
	logic [2:0] bit_cnt;
	logic [7:0] shift;

	assign selected  = ~ss_ff[1];   // Select is active low on the pin
	assign sck_rise  = sck_ff[1] & ~sck_prev;
	assign byte_data = shift;

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			sck_ff      <= 2'b00;
			sdi_ff      <= 2'b00;
			ss_ff       <= 2'b11;
			sck_prev    <= 1'b0;
			ss_prev     <= 1'b1;
			bit_cnt     <= 3'd0;
			byte_valid  <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			sck_ff      <= {sck_ff[0], sck};
			sdi_ff      <= {sdi_ff[0], sdi};
			ss_ff       <= {ss_ff[0], ss};
			sck_prev    <= sck_ff[1];
			ss_prev     <= ss_ff[1];
			frame_start <= ss_prev & ~ss_ff[1];
			byte_valid  <= 1'b0;
			// A partial byte is dropped once the select goes away
			if (!selected) begin
				bit_cnt <= 3'd0;
			end else if (sck_rise) begin
				bit_cnt    <= bit_cnt + 3'd1;
				byte_valid <= (bit_cnt == 3'd7);
			end
		end
	end

	// MSB arrives first
	always_ff @(posedge clk_gng) begin
		if (selected && sck_rise) begin
			shift <= {shift[6:0], sdi_ff[1]};
		end
	end

endmodule

//--- common/board_pkg.sv
package board_pkg;

	// Configuration commands on the CONF_DATA0 channel
	typedef enum logic [7:0] {
		cmd_joy0   = 8'h02,
		cmd_joy1   = 8'h03,
		cmd_status = 8'h15
	} user_cmd_e;

	// Which half of the ROM word the next byte fills
	typedef enum logic {
		dl_low,
		dl_high
	} dl_state_e;

	localparam int status_w = 8;

	// ROM loader bus
	localparam int rom_aw = 25;
	localparam int rom_dw = 16;

	localparam int snd_w = 9;   // Signed sample from the game

	// Colour depth, game side and VGA side
	localparam int col_w = 4;
	localparam int vga_w = 6;

endpackage
